/* flist.f */
src/qspim_pkg.sv
src/qspim_fifo.sv
src/qspim_regs.sv
src/qspim_shifter.sv
src/qspim_ctrl.sv
src/qspim_top.sv
tests/spi_flash_model.sv
tests/tb_qspim_top.sv

/* src/qspim_ctrl.sv */
/*
 * Frame sequencer
 *   Chip select, command, address and data phases
 *   Write word lane select, read word packing, CS release timing
 */

`timescale 1ns/100ps

module qspim_ctrl
    import qspim_pkg::*;
(
    input  logic       mclk,
    input  logic       rst_n_i,
    input  logic       cmd_empty_i,
    output logic       cmd_rd_o,
    input  spi_cmd_t   cmd_i,
    input  logic       wdat_empty_i,
    output logic       wdat_rd_o,
    input  word_t      wdat_i,
    input  logic       rsp_full_i,
    output logic       rsp_wr_o,
    output word_t      rsp_o,
    input  logic [7:0] clk_div_i,
    output logic       byte_go_o,
    output logic [7:0] tx_byte_o,
    input  logic       byte_done_i,
    input  logic [7:0] rx_byte_i,
    output logic [3:0] spi_csn_o,
    output logic       busy_o
);

    typedef enum logic [2:0] {
        ST_IDLE, ST_CMD, ST_ADDR, ST_DATA, ST_CSR
    } state_t;

    state_t     state;
    spi_cmd_t   cmd_q;        // Frame being sent
    logic [1:0] acnt;         // Address bytes left
    logic [7:0] dcnt;         // Data bytes left
    logic [1:0] lane;         // Byte within current word
    logic [7:0] hcnt;         // CS release delay
    logic       inflight;     // Byte with shifter
    logic       go_q;
    logic [7:0] tx_q;
    word_t      rword;        // Read word being packed
    logic       ready;
    logic [7:0] tx_next;
    logic       go_now;
    logic       is_wr;
    logic       is_rd;
    logic       word_end;
    state_t     after_hdr;

    //------------------------------------------------------------
    // Next byte and its readiness
    //------------------------------------------------------------
    always_comb begin
        ready   = 1'b0;
        tx_next = cmd_q.cmd_byte;
        case (state)
            ST_CMD:  ready = 1'b1;
            ST_ADDR: begin
                ready   = 1'b1;
                tx_next = cmd_q.addr[{acnt - 2'd1, 3'b000} +: 8];  // Upper byte first
            end
            ST_DATA: begin
                if (cmd_q.dir) begin
                    ready   = !wdat_empty_i;               // Wait for write data
                    tx_next = wdat_i[{lane, 3'b000} +: 8];  // LSB lane first
                end else begin
                    ready   = (lane != 2'd0) || !rsp_full_i;   // Room for a new word
                    tx_next = 8'h00;
                end
            end
            default: ready = 1'b0;
        endcase
    end

    assign go_now    = ready && !inflight;
    assign is_wr     = (state == ST_DATA) && cmd_q.dir;
    assign is_rd     = (state == ST_DATA) && !cmd_q.dir;
    assign word_end  = (lane == 2'd3) || (dcnt == 8'd1);
    assign after_hdr = (cmd_q.data_cnt != 8'd0) ? ST_DATA : ST_CSR;

    assign cmd_rd_o  = (state == ST_IDLE) && !cmd_empty_i;
    assign wdat_rd_o = byte_done_i && is_wr && word_end;   // Word used up
    assign rsp_wr_o  = byte_done_i && is_rd && word_end;   // Word complete

    // Pushed word includes the byte just received
    always_comb begin
        rsp_o = rword;
        rsp_o[{lane, 3'b000} +: 8] = rx_byte_i;
    end

    //------------------------------------------------------------
    // Phase sequencing
    //------------------------------------------------------------
    always_ff @(posedge mclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state     <= ST_IDLE;
            acnt      <= '0;
            dcnt      <= '0;
            lane      <= '0;
            hcnt      <= '0;
            inflight  <= 1'b0;
            go_q      <= 1'b0;
            spi_csn_o <= 4'b1111;
        end else begin
            go_q <= go_now;
            if (go_now)
                inflight <= 1'b1;
            else if (byte_done_i)
                inflight <= 1'b0;
            if (byte_done_i)
                hcnt <= 8'd1;          // Counts from the last falling edge
            case (state)
                ST_IDLE: if (!cmd_empty_i) begin
                    spi_csn_o <= ~(4'b0001 << cmd_i.cs);   // Selected CS low
                    state     <= ST_CMD;
                end
                ST_CMD: if (byte_done_i) begin
                    acnt  <= cmd_q.addr_cnt;
                    dcnt  <= cmd_q.data_cnt;
                    lane  <= '0;
                    state <= (cmd_q.addr_cnt != 2'd0) ? ST_ADDR : after_hdr;
                end
                ST_ADDR: if (byte_done_i) begin
                    acnt <= acnt - 1'b1;
                    if (acnt == 2'd1)
                        state <= after_hdr;
                end
                ST_DATA: if (byte_done_i) begin
                    dcnt <= dcnt - 1'b1;
                    lane <= lane + 1'b1;     // Wraps every word
                    if (dcnt == 8'd1)
                        state <= ST_CSR;
                end
                ST_CSR: begin
                    if (hcnt >= clk_div_i) begin   // One half-period elapsed
                        spi_csn_o <= 4'b1111;
                        state     <= ST_IDLE;
                    end else begin
                        hcnt <= hcnt + 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Frame, byte and read word payload
    always_ff @(posedge mclk) begin
        if (cmd_rd_o)
            cmd_q <= cmd_i;
        if (go_now)
            tx_q <= tx_next;
        if (go_now && is_rd && (lane == 2'd0))
            rword <= '0;                       // Zero fill for short last word
        else if (byte_done_i && is_rd)
            rword[{lane, 3'b000} +: 8] <= rx_byte_i;
    end

    assign byte_go_o = go_q;
    assign tx_byte_o = tx_q;
    assign busy_o    = (state != ST_IDLE) || !cmd_empty_i;

endmodule

/* src/qspim_fifo.sv */
/*
 * Synchronous FIFO, payload type set by parameter
 *   Circular buffer with read and write pointers and a fill count
 *   Head entry shown on rdata_o
 */

`timescale 1ns/100ps

module qspim_fifo #(
    parameter type T     = logic [31:0],
    parameter int  DEPTH = 2
) (
    input  logic mclk,
    input  logic rst_n_i,
    input  logic wr_i,       // Push, ignored when full
    input  T     wdata_i,
    output logic full_o,
    input  logic rd_i,       // Pop, ignored when empty
    output T     rdata_o,
    output logic empty_o
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    T              mem [DEPTH];
    logic [AW-1:0] wptr;
    logic [AW-1:0] rptr;
    logic [CW-1:0] count;
    logic          push;
    logic          pop;

    assign push    = wr_i && !full_o;
    assign pop     = rd_i && !empty_o;
    assign full_o  = (count == CW'(DEPTH));
    assign empty_o = (count == '0);
    assign rdata_o = mem[rptr];

    // Pointers and fill level
    always_ff @(posedge mclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end else begin
            if (push)
                wptr <= (wptr == AW'(DEPTH - 1)) ? '0 : wptr + 1'b1;   // Wrap
            if (pop)
                rptr <= (rptr == AW'(DEPTH - 1)) ? '0 : rptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;          // Both or neither
            endcase
        end
    end

    // Storage
    always_ff @(posedge mclk) begin
        if (push)
            mem[wptr] <= wdata_i;
    end

endmodule

/* src/qspim_pkg.sv */
/*
 * Shared definitions for the SPI flash master
 *   Wishbone width, data word type and register word offsets
 *   Frame descriptor carried by the command FIFO
 *   Bundled Wishbone request
 */

package qspim_pkg;

    // Bus width and data word
    localparam int WB_WIDTH = 32;

    typedef logic [WB_WIDTH-1:0] word_t;

    //------------------------------------------------------------
    // Register map, word offsets
    //------------------------------------------------------------
    localparam logic [1:0] REG_CTRL = 2'd0;   // Divider, CS index, busy
    localparam logic [1:0] REG_ADDR = 2'd1;   // 24-bit flash address
    localparam logic [1:0] REG_CMD  = 2'd2;   // Frame start
    localparam logic [1:0] REG_DATA = 2'd3;   // Write FIFO push / read FIFO pop

    // CTRL fields
    localparam int CTRL_DIV_LSB  = 0;
    localparam int CTRL_CS_LSB   = 8;
    localparam int CTRL_BUSY_BIT = 31;

    // CMD word fields
    localparam int CMD_BYTE_LSB  = 0;
    localparam int CMD_ACNT_LSB  = 8;
    localparam int CMD_DCNT_LSB  = 10;
    localparam int CMD_DIR_BIT   = 18;

    //------------------------------------------------------------
    // One SPI frame, 45 bits
    //------------------------------------------------------------
    typedef struct packed {
        logic [7:0]  cmd_byte;   // Opcode sent first
        logic [23:0] addr;       // Flash address
        logic [1:0]  addr_cnt;   // Address bytes, 0..3
        logic [7:0]  data_cnt;   // Data bytes, 0..255
        logic        dir;        // 1 = write
        logic [1:0]  cs;         // Chip select index
    } spi_cmd_t;

    // Wishbone request as seen by the register block
    typedef struct packed {
        logic        stb;
        logic [1:0]  adr;        // Word offset
        logic        we;
        word_t       dat;
    } wb_req_t;

endpackage

/* src/qspim_regs.sv */
/*
 * Wishbone register block
 *   CTRL and ADDR registers, CMD and DATA windows
 *   Ack gated on command, write and response FIFO state
 */

`timescale 1ns/100ps

module qspim_regs
    import qspim_pkg::*;
(
    input  logic     mclk,
    input  logic     rst_n_i,
    input  wb_req_t  wb_req_i,
    output word_t    wbd_dat_o,
    output logic     wbd_ack_o,
    input  logic     busy_i,        // Frame active or pending
    output logic [7:0] clk_div_o,
    output logic     cmd_wr_o,
    output spi_cmd_t cmd_o,
    input  logic     cmd_full_i,
    output logic     wdat_wr_o,
    output word_t    wdat_o,
    input  logic     wdat_full_i,
    output logic     rsp_rd_o,
    input  word_t    rsp_i,
    input  logic     rsp_empty_i
);

    logic [7:0]  clk_div_q;
    logic [1:0]  cs_q;
    logic [23:0] addr_q;
    logic        ack_q;
    word_t       dat_q;
    logic        can_ack;     // Target ready for this access
    logic        do_ack;      // Access completes this cycle
    word_t       rd_mux;

    //------------------------------------------------------------
    // Access decode
    //------------------------------------------------------------
    always_comb begin
        can_ack = 1'b1;
        rd_mux  = '0;
        case (wb_req_i.adr)
            REG_CTRL: begin
                rd_mux[CTRL_DIV_LSB +: 8] = clk_div_q;
                rd_mux[CTRL_CS_LSB +: 2]  = cs_q;
                rd_mux[CTRL_BUSY_BIT]     = busy_i;   // Read-only status
            end
            REG_ADDR: rd_mux = {8'h00, addr_q};
            REG_CMD:  can_ack = !wb_req_i.we || !cmd_full_i;
            REG_DATA: begin
                can_ack = wb_req_i.we ? !wdat_full_i : !rsp_empty_i;
                rd_mux  = rsp_i;                      // Head of response FIFO
            end
            default: can_ack = 1'b1;
        endcase
    end

    assign do_ack = wb_req_i.stb && !ack_q && can_ack;   // One pulse per access

    // FIFO strobes, same edge as ack
    assign cmd_wr_o  = do_ack && wb_req_i.we && (wb_req_i.adr == REG_CMD);
    assign wdat_wr_o = do_ack && wb_req_i.we && (wb_req_i.adr == REG_DATA);
    assign rsp_rd_o  = do_ack && !wb_req_i.we && (wb_req_i.adr == REG_DATA);
    assign wdat_o    = wb_req_i.dat;

    // Frame descriptor from CMD word, ADDR and CTRL chip select
    assign cmd_o.cmd_byte = wb_req_i.dat[CMD_BYTE_LSB +: 8];
    assign cmd_o.addr     = addr_q;
    assign cmd_o.addr_cnt = wb_req_i.dat[CMD_ACNT_LSB +: 2];
    assign cmd_o.data_cnt = wb_req_i.dat[CMD_DCNT_LSB +: 8];
    assign cmd_o.dir      = wb_req_i.dat[CMD_DIR_BIT];
    assign cmd_o.cs       = cs_q;

    //------------------------------------------------------------
    // Registers
    //------------------------------------------------------------
    always_ff @(posedge mclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            clk_div_q <= '0;
            cs_q      <= '0;
            addr_q    <= '0;
            ack_q     <= 1'b0;
            dat_q     <= '0;
        end else begin
            ack_q <= do_ack;
            if (do_ack && wb_req_i.we) begin
                if (wb_req_i.adr == REG_CTRL) begin
                    clk_div_q <= wb_req_i.dat[CTRL_DIV_LSB +: 8];
                    cs_q      <= wb_req_i.dat[CTRL_CS_LSB +: 2];
                end
                if (wb_req_i.adr == REG_ADDR)
                    addr_q <= wb_req_i.dat[23:0];
            end
            if (do_ack && !wb_req_i.we)
                dat_q <= rd_mux;             // Held until next read
        end
    end

    assign wbd_ack_o = ack_q;
    assign wbd_dat_o = dat_q;
    assign clk_div_o = clk_div_q;

endmodule

/* src/qspim_shifter.sv */
/*
 * SPI mode 0 byte engine
 *   Clock divider, half-period of div+1 cycles
 *   MSB-first shift out on falling edge, sample on rising edge
 */

`timescale 1ns/100ps

module qspim_shifter (
    input  logic       mclk,
    input  logic       rst_n_i,
    input  logic [7:0] clk_div_i,
    input  logic       byte_go_i,     // Start one byte
    input  logic [7:0] tx_byte_i,
    output logic       byte_done_o,   // Pulse after 16 half-periods
    output logic [7:0] rx_byte_o,
    output logic       spi_clk_o,
    output logic       spi_sdo_o,
    input  logic       spi_sdi_i
);

    logic       active;
    logic [7:0] div_cnt;
    logic [2:0] bit_cnt;
    logic       clk_q;
    logic [7:0] tx_sh;
    logic [7:0] rx_sh;
    logic       done_q;

    always_ff @(posedge mclk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            active  <= 1'b0;
            div_cnt <= '0;
            bit_cnt <= '0;
            clk_q   <= 1'b0;          // Idle low
            tx_sh   <= '0;            // MOSI low out of reset
            rx_sh   <= '0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (byte_go_i) begin
                active  <= 1'b1;
                div_cnt <= '0;
                bit_cnt <= '0;
                tx_sh   <= tx_byte_i;     // MSB on MOSI before first rise
            end else if (active) begin
                if (div_cnt == clk_div_i) begin
                    div_cnt <= '0;
                    clk_q   <= !clk_q;
                    if (!clk_q) begin
                        rx_sh <= {rx_sh[6:0], spi_sdi_i};   // Rising edge, sample
                    end else begin
                        // Falling edge, next bit out
                        tx_sh   <= {tx_sh[6:0], 1'b0};
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            active <= 1'b0;
                            done_q <= 1'b1;
                        end
                    end
                end else begin
                    div_cnt <= div_cnt + 1'b1;
                end
            end
        end
    end

    assign byte_done_o = done_q;
    assign rx_byte_o   = rx_sh;
    assign spi_clk_o   = clk_q;
    assign spi_sdo_o   = tx_sh[7];

endmodule

/* src/qspim_top.sv */
/*
 * SPI flash master top level
 *   Register block, command, write and response FIFOs
 *   Frame sequencer and byte shifter
 */

`timescale 1ns/100ps

module qspim_top
    import qspim_pkg::*;
#(
    parameter int CMD_DEPTH  = 2,
    parameter int DATA_DEPTH = 8
) (
    input  logic       mclk,
    input  logic       rst_n_i,
    input  logic       wbd_stb_i,
    input  logic [3:0] wbd_adr_i,    // Byte address, word aligned
    input  logic       wbd_we_i,
    input  word_t      wbd_dat_i,
    output word_t      wbd_dat_o,
    output logic       wbd_ack_o,
    output logic       spi_clk_o,
    output logic [3:0] spi_csn_o,
    output logic       spi_sdo_o,
    input  logic       spi_sdi_i
);

    wb_req_t    wb_req;
    logic [7:0] clk_div;
    logic       busy;
    // Command FIFO
    logic       cmd_wr, cmd_rd, cmd_full, cmd_empty;
    spi_cmd_t   cmd_wdata, cmd_rdata;
    // Write data FIFO
    logic       wdat_wr, wdat_rd, wdat_full, wdat_empty;
    word_t      wdat_wdata, wdat_rdata;
    // Response FIFO
    logic       rsp_wr, rsp_rd, rsp_full, rsp_empty;
    word_t      rsp_wdata, rsp_rdata;
    // Sequencer to shifter
    logic       byte_go, byte_done;
    logic [7:0] tx_byte, rx_byte;

    assign wb_req = '{stb: wbd_stb_i, adr: wbd_adr_i[3:2], we: wbd_we_i, dat: wbd_dat_i};

    qspim_regs u_regs (
        .mclk, .rst_n_i, .wb_req_i(wb_req), .wbd_dat_o, .wbd_ack_o, .busy_i(busy),
        .clk_div_o(clk_div), .cmd_wr_o(cmd_wr), .cmd_o(cmd_wdata), .cmd_full_i(cmd_full),
        .wdat_wr_o(wdat_wr), .wdat_o(wdat_wdata), .wdat_full_i(wdat_full),
        .rsp_rd_o(rsp_rd), .rsp_i(rsp_rdata), .rsp_empty_i(rsp_empty)
    );

    qspim_fifo #(.T(spi_cmd_t), .DEPTH(CMD_DEPTH)) u_cmd_fifo (
        .mclk, .rst_n_i, .wr_i(cmd_wr), .wdata_i(cmd_wdata), .full_o(cmd_full),
        .rd_i(cmd_rd), .rdata_o(cmd_rdata), .empty_o(cmd_empty)
    );

    qspim_fifo #(.T(word_t), .DEPTH(DATA_DEPTH)) u_wdat_fifo (
        .mclk, .rst_n_i, .wr_i(wdat_wr), .wdata_i(wdat_wdata), .full_o(wdat_full),
        .rd_i(wdat_rd), .rdata_o(wdat_rdata), .empty_o(wdat_empty)
    );

    qspim_fifo #(.T(word_t), .DEPTH(DATA_DEPTH)) u_rsp_fifo (
        .mclk, .rst_n_i, .wr_i(rsp_wr), .wdata_i(rsp_wdata), .full_o(rsp_full),
        .rd_i(rsp_rd), .rdata_o(rsp_rdata), .empty_o(rsp_empty)
    );

    qspim_ctrl u_ctrl (
        .mclk, .rst_n_i, .cmd_empty_i(cmd_empty), .cmd_rd_o(cmd_rd), .cmd_i(cmd_rdata),
        .wdat_empty_i(wdat_empty), .wdat_rd_o(wdat_rd), .wdat_i(wdat_rdata),
        .rsp_full_i(rsp_full), .rsp_wr_o(rsp_wr), .rsp_o(rsp_wdata), .clk_div_i(clk_div),
        .byte_go_o(byte_go), .tx_byte_o(tx_byte), .byte_done_i(byte_done),
        .rx_byte_i(rx_byte), .spi_csn_o, .busy_o(busy)
    );

    qspim_shifter u_shifter (
        .mclk, .rst_n_i, .clk_div_i(clk_div), .byte_go_i(byte_go), .tx_byte_i(tx_byte),
        .byte_done_o(byte_done), .rx_byte_o(rx_byte), .spi_clk_o, .spi_sdo_o, .spi_sdi_i
    );

endmodule

/* tests/qspim_stim.txt */
# Columns: opcode, then hex operands; register offsets are byte addresses 0 4 8 c
# WR adr dat, RD adr exp, RDWAIT min_cycles exp, IDLE, MOSI n bytes, HALF cycles
# PINS csn clk, CSEL csn, DELAY cycles
PINS f 0
RD 0 00000000
WR 0 00000201
WR 4 00123456
RD 0 00000201
RD 4 00123456
# Write frame, CS 2, 3 address bytes, 6 data bytes
WR c 44332211
WR c 88776655
WR 8 00041b02
IDLE
MOSI a 02 12 34 56 11 22 33 44 55 66
CSEL b
# Read frame, 1 address byte, 6 data bytes
WR 8 00001903
IDLE
RD c a0a1a6a7
RD c 0000a2a3
MOSI 8 03 56 00 00 00 00 00 00
# Divider 3, command byte only
WR 0 00000003
WR 8 0000009f
HALF 4
IDLE
MOSI 1 9f
# DATA read issued before the first word exists, 7 bytes of 16 cycles
WR 0 00000100
WR 8 0000160b
RDWAIT 70 a3a0a1a6
RD c 000000a2
IDLE
CSEL d
# Write frame stalled on an empty write FIFO
WR 0 00000300
WR 8 00041312
DELAY c8
PINS 7 0
RD 0 80000300
WR c ddccbbaa
IDLE
MOSI 8 12 12 34 56 aa bb cc dd
CSEL 7

/* tests/spi_flash_model.sv */
/*
 * Behavioral SPI flash, mode 0
 *   Logs every MOSI byte, frame start index kept per CS-low frame
 *   Answers byte k of a frame with k XOR 0xA5 on MISO
 */

`timescale 1ns/100ps

module spi_flash_model (
    input  logic sck_i,
    input  logic csn_i,      // Low while any chip select is active
    input  logic mosi_i,
    output logic miso_o
);

    logic [7:0] mosi_log [256];   // Every byte seen on MOSI
    int         log_cnt;
    int         frame_base;       // Log index of current frame's first byte
    int         byte_idx;         // Byte within frame
    int         bit_idx;
    logic [7:0] rx_sh;
    logic [7:0] reply;

    initial begin
        log_cnt    = 0;
        frame_base = 0;
        byte_idx   = 0;
        bit_idx    = 0;
        rx_sh      = '0;
        reply      = '0;
        miso_o     = 1'b0;
    end

    // Frame start, MSB of first reply ready before first rising edge
    always @(negedge csn_i) begin
        frame_base = log_cnt;
        byte_idx   = 0;
        bit_idx    = 0;
        reply      = 8'h00 ^ 8'ha5;
        miso_o     = reply[7];
    end

    always @(posedge sck_i) begin
        if (!csn_i) begin
            rx_sh   = {rx_sh[6:0], mosi_i};   // MSB first
            bit_idx = bit_idx + 1;
            if (bit_idx == 8) begin
                mosi_log[log_cnt] = rx_sh;
                log_cnt  = log_cnt + 1;
                byte_idx = byte_idx + 1;
                bit_idx  = 0;
            end
        end
    end

    // Next MISO bit on the falling edge
    always @(negedge sck_i) begin
        if (!csn_i) begin
            reply  = byte_idx[7:0] ^ 8'ha5;
            miso_o = reply[7 - bit_idx];
        end
    end

endmodule

/* tests/tb_qspim_top.sv */
/*
 * Testbench for the SPI flash master
 *   Clock, reset, Wishbone ops read from the stimulus file
 *   Compare tasks for words, MOSI bytes and single pins
 */

`timescale 1ns/100ps

module tb_qspim_top
    import qspim_pkg::*;
;

    localparam int ACK_TIMEOUT  = 2000;   // mclk cycles per Wishbone access
    localparam int POLL_TIMEOUT = 2000;   // CTRL reads while busy
    localparam int CLK_TIMEOUT  = 1000;   // mclk cycles per SPI clock level

    logic       mclk;
    logic       rst_n;
    logic       wbd_stb;
    logic [3:0] wbd_adr;
    logic       wbd_we;
    word_t      wbd_dat_w;
    word_t      wbd_dat_r;
    logic       wbd_ack;
    logic       spi_clk;
    logic [3:0] spi_csn;
    logic       spi_sdo;
    logic       spi_sdi;
    logic       any_csn;
    logic [3:0] cs_seen;       // Last active chip select pattern
    int         seed = 75280;  // Seed for $random

    qspim_top #(.CMD_DEPTH(2), .DATA_DEPTH(8)) qspim_top_inst (
        .mclk(mclk), .rst_n_i(rst_n), .wbd_stb_i(wbd_stb), .wbd_adr_i(wbd_adr),
        .wbd_we_i(wbd_we), .wbd_dat_i(wbd_dat_w), .wbd_dat_o(wbd_dat_r),
        .wbd_ack_o(wbd_ack), .spi_clk_o(spi_clk), .spi_csn_o(spi_csn),
        .spi_sdo_o(spi_sdo), .spi_sdi_i(spi_sdi)
    );

    assign any_csn = &spi_csn;   // Low while any CS is low

    spi_flash_model u_flash (
        .sck_i(spi_clk), .csn_i(any_csn), .mosi_i(spi_sdo), .miso_o(spi_sdi)
    );

    initial begin
        mclk = 1'b0;
        forever #2 mclk = ~mclk;   // 4 ns period
    end

    initial cs_seen = 4'hf;
    always @(spi_csn) begin
        if (spi_csn !== 4'hf)
            cs_seen = spi_csn;
    end

    //------------------------------------------------------------
    // Error stop and compare tasks
    //------------------------------------------------------------
    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp)
            fail_run($sformatf("[FAIL] %0.1f ns %s got %h expected %h",
                               $realtime, name, got, exp));
    endtask

    task automatic check_byte(input string name, input logic [7:0] got,
                              input logic [7:0] exp);
        if (got !== exp)
            fail_run($sformatf("[FAIL] %0.1f ns %s got %h expected %h",
                               $realtime, name, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            fail_run($sformatf("[FAIL] %0.1f ns %s got %b expected %b",
                               $realtime, name, got, exp));
    endtask

    //------------------------------------------------------------
    // Wishbone access, SPI clock measurement, busy poll
    //------------------------------------------------------------
    // Starts and ends 1 ns after a rising edge
    task automatic bus_access(input logic [3:0] adr, input logic we, input word_t dat,
                              output word_t rdat, output int cycles);
        cycles    = 0;
        wbd_stb   = 1'b1;
        wbd_adr   = adr;
        wbd_we    = we;
        wbd_dat_w = dat;
        // Ack of the previous access can still be high here
        do begin
            @(posedge mclk);
            #1;
            cycles++;
        end while (!wbd_ack && cycles < ACK_TIMEOUT);
        if (!wbd_ack) begin
            fail_run($sformatf("No Wishbone ack within %0d cycles at offset %h",
                               ACK_TIMEOUT, adr));
        end else begin
            rdat    = wbd_dat_r;      // Held by DUT after ack
            wbd_stb = 1'b0;
            wbd_we  = 1'b0;
        end
    endtask

    task automatic wait_idle();
        word_t rdat;
        int    cycles;
        int    polls;
        polls = 0;
        bus_access({REG_CTRL, 2'b00}, 1'b0, '0, rdat, cycles);
        while (rdat[CTRL_BUSY_BIT] && polls < POLL_TIMEOUT) begin
            bus_access({REG_CTRL, 2'b00}, 1'b0, '0, rdat, cycles);
            polls++;
        end
        if (rdat[CTRL_BUSY_BIT])
            fail_run($sformatf("Busy bit still set after %0d CTRL reads", POLL_TIMEOUT));
    endtask

    // High time of the first SPI clock pulse, in mclk cycles
    task automatic measure_half(output int cycles);
        int waited;
        waited = 0;
        cycles = 0;
        while (!spi_clk && waited < CLK_TIMEOUT) begin
            @(posedge mclk);
            #1;
            waited++;
        end
        if (!spi_clk)
            fail_run("SPI clock never rose while measuring its half-period");
        while (spi_clk && cycles < CLK_TIMEOUT) begin
            @(posedge mclk);
            #1;
            cycles++;
        end
    endtask

    //------------------------------------------------------------
    // Stimulus file interpreter
    //------------------------------------------------------------
    initial begin
        int               fd;
        int               rc;
        int               cycles;
        logic [63:0]      op;
        logic [8*128-1:0] rest;
        word_t            a;
        word_t            b;
        word_t            rdat;
        rst_n     = 1'b0;
        wbd_stb   = 1'b0;
        wbd_adr   = '0;
        wbd_we    = 1'b0;
        wbd_dat_w = '0;
        fd = $fopen("tests/qspim_stim.txt", "r");
        if (fd == 0)
            fail_run("Cannot open stimulus file tests/qspim_stim.txt");
        repeat (5) @(posedge mclk);
        #1 rst_n = 1'b1;
        while ($fscanf(fd, "%s", op) == 1) begin
            case (op)
                "#":    rc = $fgets(rest, fd);   // Comment line
                "WR": begin
                    rc = $fscanf(fd, "%h %h", a, b);
                    bus_access(a[3:0], 1'b1, b, rdat, cycles);
                end
                "RD": begin
                    rc = $fscanf(fd, "%h %h", a, b);
                    bus_access(a[3:0], 1'b0, '0, rdat, cycles);
                    check_word("wbd_dat_o", rdat, b);
                end
                "RDWAIT": begin                     // a = least cycles before ack
                    rc = $fscanf(fd, "%h %h", a, b);
                    bus_access({REG_DATA, 2'b00}, 1'b0, '0, rdat, cycles);
                    if (cycles < a)
                        fail_run($sformatf("DATA read acked after %0d cycles, before %0d",
                                           cycles, a));
                    check_word("wbd_dat_o", rdat, b);
                end
                "IDLE": wait_idle();
                "MOSI": begin                       // Bytes of the last frame
                    rc = $fscanf(fd, "%h", a);
                    check_word("MOSI byte count", u_flash.log_cnt - u_flash.frame_base, a);
                    for (int i = 0; i < a; i++) begin
                        rc = $fscanf(fd, "%h", b);
                        check_byte($sformatf("MOSI byte %0d", i),
                                   u_flash.mosi_log[u_flash.frame_base + i], b[7:0]);
                    end
                end
                "HALF": begin
                    rc = $fscanf(fd, "%h", a);
                    measure_half(cycles);
                    check_word("spi_clk_o half-period", cycles, a);
                end
                "PINS": begin
                    rc = $fscanf(fd, "%h %h", a, b);
                    for (int i = 0; i < 4; i++)
                        check_bit($sformatf("spi_csn_o[%0d]", i), spi_csn[i], a[i]);
                    check_bit("spi_clk_o", spi_clk, b[0]);
                end
                "CSEL": begin
                    rc = $fscanf(fd, "%h", a);
                    for (int i = 0; i < 4; i++)
                        check_bit($sformatf("active spi_csn_o[%0d]", i), cs_seen[i], a[i]);
                end
                "DELAY": begin
                    rc = $fscanf(fd, "%h", a);
                    repeat (a) @(posedge mclk);
                    #1;                             // Back to the drive point
                end
                default: fail_run($sformatf("Unknown opcode %0s in stimulus file", op));
            endcase
        end
        $fclose(fd);
        $display("NO ERRORS");
        $finish;
    end

endmodule
